// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rx_intf
FILELIST = list.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== list.f ====
+incdir+.
rx_intf_pkg.sv
rx_sync_fifo.sv
rx_intf_regs.sv
rx_byte_packer.sv
rx_stream_out.sv
rx_intf_top.sv
rx_intf_props.sv
tb_rx_intf.sv

// ==== rx_byte_packer.sv ====
// rx_byte_packer: packs decoder bytes into header and data words and writes packet descriptors
`timescale 1ns/1ps
`include "rx_intf_defines.svh"

module rx_byte_packer
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 ctrl_enable,
    input  logic                                 hdr_strobe,
    input  rx_intf_pkg::pkt_hdr_t                hdr,
    input  logic [7:0]                           byte_in,
    input  logic                                 byte_strobe,
    input  logic                                 fcs_strobe,
    input  logic                                 fcs_ok,
    input  logic [$clog2(`RX_DATA_DEPTH+1)-1:0] data_count,
    input  logic                                 desc_full,
    output logic                                 word_push,
    output rx_intf_pkg::rx_word_t                word_data,
    output logic                                 desc_push,
    output rx_intf_pkg::pkt_desc_t               desc_data,
    output logic                                 refused_pulse,
    output logic [15:0]                          next_sn
);
    localparam int IDX_W = $clog2(`RX_BYTES_PER_WORD);

    logic                  active;
    logic [IDX_W-1:0]      byte_idx;
    logic [15:0]           word_cnt;
    logic [`RX_WORD_W-1:0] acc;
    logic [`RX_WORD_W-1:0] acc_next;
    logic [7:0]            room;
    logic [16:0]           need;
    logic                  hdr_fits;
    logic                  hdr_take;
    logic                  byte_take;
    logic                  fcs_take;
    logic                  word_done;

    // a push in flight this cycle is not yet in data_count
    assign room = 8'(`RX_DATA_DEPTH) - {1'b0, data_count} - {7'd0, word_push};
    assign need = {1'b0, hdr.len / 16'(`RX_BYTES_PER_WORD)} + 17'd2;
    assign hdr_fits = ({9'd0, room} >= need) && !desc_full;

    assign hdr_take  = hdr_strobe && ctrl_enable && hdr_fits;
    assign byte_take = active && byte_strobe && !hdr_strobe;
    assign fcs_take  = active && fcs_strobe && !hdr_strobe && !byte_strobe;
    assign word_done = byte_take && (byte_idx == IDX_W'(`RX_BYTES_PER_WORD - 1));

    // byte 0 of a word clears the stale upper bytes
    always_comb
    begin
        acc_next = (byte_idx == '0) ? '0 : acc;
        acc_next[byte_idx*8 +: 8] = byte_in;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active        <= 1'b0;
            byte_idx      <= '0;
            word_cnt      <= '0;
            next_sn       <= '0;
            word_push     <= 1'b0;
            desc_push     <= 1'b0;
            refused_pulse <= 1'b0;
        end
        else
        begin
            word_push     <= hdr_take || word_done || (fcs_take && byte_idx != '0);
            desc_push     <= fcs_take;
            refused_pulse <= hdr_strobe && ctrl_enable && !hdr_fits;
            if (hdr_strobe)
            begin
                // refused or disabled packets leave active low
                active   <= hdr_take;
                byte_idx <= '0;
                word_cnt <= 16'd1;
            end
            else if (byte_take)
            begin
                byte_idx <= byte_idx + 1'b1;
                if (word_done)
                    word_cnt <= word_cnt + 1'b1;
            end
            else if (fcs_take)
            begin
                active  <= 1'b0;
                next_sn <= next_sn + 1'b1;
            end
        end
    end

    // payload path
    always_ff @(posedge clk)
    begin
        if (byte_take)
            acc <= acc_next;
        if (hdr_take)
            word_data.data <= {next_sn, hdr.len, hdr.rate, 22'd0, hdr.ht_sgi, hdr.ht_aggr};
        else if (word_done)
            word_data.data <= acc_next;
        else if (fcs_take)
            word_data.data <= acc;
        if (fcs_take)
        begin
            // partial word still to flush adds one
            desc_data.num_words <= (byte_idx != '0) ? word_cnt + 1'b1 : word_cnt;
            desc_data.fcs_ok    <= fcs_ok;
        end
    end

endmodule

// ==== rx_intf_defines.svh ====
// data widths, FIFO depths and AXI4-Lite register offsets for the rx interface
`ifndef RX_INTF_DEFINES_SVH
`define RX_INTF_DEFINES_SVH

// stream word
`define RX_WORD_W          64
`define RX_BYTES_PER_WORD  8

// buffer depths in words and in packets
`define RX_DATA_DEPTH      64
`define RX_DESC_DEPTH      8

// statistics counter width
`define RX_CNT_W           16

// AXI4-Lite bus
`define RX_AXIL_ADDR_W     4
`define RX_AXIL_DATA_W     32

// register byte offsets
`define RX_REG_CTRL        4'h0
`define RX_REG_DELIVERED   4'h4
`define RX_REG_DROPPED     4'h8
`define RX_REG_NEXT_SN     4'hC

`endif

// ==== rx_intf_pkg.sv ====
// package rx_intf_pkg with decoder header, word, descriptor, control and bus struct types
`include "rx_intf_defines.svh"

package rx_intf_pkg;

    // header fields from the packet decoder, 26 bits
    typedef struct packed {
        logic [7:0]  rate;
        logic [15:0] len;
        logic        ht_aggr;
        logic        ht_sgi;
    } pkt_hdr_t;

    typedef struct packed {
        logic [`RX_WORD_W-1:0] data;
    } rx_word_t;

    // one queued packet, word count includes the header word
    typedef struct packed {
        logic [15:0] num_words;
        logic        fcs_ok;
    } pkt_desc_t;

    // last member is bit 0 of CTRL
    typedef struct packed {
        logic intr_enable;
        logic drop_bad_fcs;
        logic enable;
    } rx_ctrl_t;

    typedef struct packed {
        logic [`RX_AXIL_ADDR_W-1:0]   awaddr;
        logic                         awvalid;
        logic [`RX_AXIL_DATA_W-1:0]   wdata;
        logic [`RX_AXIL_DATA_W/8-1:0] wstrb;
        logic                         wvalid;
        logic                         bready;
        logic [`RX_AXIL_ADDR_W-1:0]   araddr;
        logic                         arvalid;
        logic                         rready;
    } axil_req_t;

    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic [1:0]                 bresp;
        logic                       bvalid;
        logic                       arready;
        logic [`RX_AXIL_DATA_W-1:0] rdata;
        logic [1:0]                 rresp;
        logic                       rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic                  tvalid;
        logic [`RX_WORD_W-1:0] tdata;
        logic                  tlast;
    } axis_out_t;

endpackage

// ==== rx_intf_props.sv ====
// rx_intf_props: AXI4-Stream stall hold and packet interrupt assertions, bound to rx_stream_out
`timescale 1ns/1ps

module rx_intf_props
(
    input logic                   clk,
    input logic                   rst,
    input logic                   intr_enable,
    input logic                   m_axis_tready,
    input rx_intf_pkg::axis_out_t m_axis,
    input logic                   rx_pkt_intr
);

    // a stalled beat keeps valid, data and last
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        m_axis.tvalid && !m_axis_tready |=>
            m_axis.tvalid && $stable(m_axis.tdata) && $stable(m_axis.tlast))
        else $error("stream beat changed while stalled");

    // interrupt only right after an enabled tlast transfer
    intr_after_last: assert property (@(posedge clk) disable iff (rst)
        rx_pkt_intr |->
            $past(m_axis.tvalid && m_axis_tready && m_axis.tlast && intr_enable))
        else $error("packet interrupt without a preceding tlast beat");

    // every enabled tlast transfer raises the interrupt
    intr_per_last: assert property (@(posedge clk) disable iff (rst)
        m_axis.tvalid && m_axis_tready && m_axis.tlast && intr_enable |=> rx_pkt_intr)
        else $error("missing packet interrupt after a tlast beat");

endmodule

bind rx_stream_out rx_intf_props u_props (
    .clk           (clk),
    .rst           (rst),
    .intr_enable   (intr_enable),
    .m_axis_tready (m_axis_tready),
    .m_axis        (m_axis),
    .rx_pkt_intr   (rx_pkt_intr)
);

// ==== rx_intf_regs.sv ====
// rx_intf_regs: AXI4-Lite slave with CTRL and the delivered, dropped and sequence readbacks
`timescale 1ns/1ps
`include "rx_intf_defines.svh"

module rx_intf_regs
(
    input  logic                   clk,
    input  logic                   rst,
    input  rx_intf_pkg::axil_req_t axil_req,
    input  logic                   refused_pulse,
    input  logic                   discard_pulse,
    input  logic                   deliver_pulse,
    input  logic [15:0]            next_sn,
    output rx_intf_pkg::axil_rsp_t axil_rsp,
    output rx_intf_pkg::rx_ctrl_t  ctrl
);
    logic                       awready;
    logic                       bvalid;
    logic                       arready;
    logic                       rvalid;
    logic [`RX_AXIL_DATA_W-1:0] rdata;
    logic [`RX_AXIL_DATA_W-1:0] rd_mux;
    logic [`RX_CNT_W-1:0]       delivered_cnt;
    logic [`RX_CNT_W-1:0]       dropped_cnt;
    logic [1:0]                 drop_inc;
    logic                       wr_go;
    logic                       rd_go;

    // one write or read in flight at a time
    assign wr_go = axil_req.awvalid && axil_req.wvalid && !awready && !bvalid;
    assign rd_go = axil_req.arvalid && !arready && !rvalid;

    // both drop sources can fire in the same cycle
    assign drop_inc = {1'b0, refused_pulse} + {1'b0, discard_pulse};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            ctrl    <= '0;
        end
        else
        begin
            awready <= wr_go;
            if (awready)
            begin
                bvalid <= 1'b1;
                // read-only offsets fall through untouched
                if (axil_req.awaddr == `RX_REG_CTRL && axil_req.wstrb[0])
                begin
                    ctrl.enable       <= axil_req.wdata[0];
                    ctrl.drop_bad_fcs <= axil_req.wdata[1];
                    ctrl.intr_enable  <= axil_req.wdata[2];
                end
            end
            else if (axil_req.bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            arready <= rd_go;
            if (arready)
                rvalid <= 1'b1;
            else if (axil_req.rready)
                rvalid <= 1'b0;
        end
    end

    always_comb
    begin
        case (axil_req.araddr)
            `RX_REG_CTRL:      rd_mux = {{(`RX_AXIL_DATA_W-3){1'b0}}, ctrl};
            `RX_REG_DELIVERED: rd_mux = {{(`RX_AXIL_DATA_W-`RX_CNT_W){1'b0}}, delivered_cnt};
            `RX_REG_DROPPED:   rd_mux = {{(`RX_AXIL_DATA_W-`RX_CNT_W){1'b0}}, dropped_cnt};
            `RX_REG_NEXT_SN:   rd_mux = {{(`RX_AXIL_DATA_W-16){1'b0}}, next_sn};
            default:           rd_mux = '0;
        endcase
    end

    // araddr is still held by the master in the arready cycle
    always_ff @(posedge clk)
    begin
        if (arready)
            rdata <= rd_mux;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            delivered_cnt <= '0;
            dropped_cnt   <= '0;
        end
        else
        begin
            if (deliver_pulse)
                delivered_cnt <= delivered_cnt + 1'b1;
            dropped_cnt <= dropped_cnt + {{(`RX_CNT_W-2){1'b0}}, drop_inc};
        end
    end

    always_comb
    begin
        axil_rsp.awready = awready;
        axil_rsp.wready  = awready;
        axil_rsp.bresp   = 2'b00;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = arready;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = 2'b00;
        axil_rsp.rvalid  = rvalid;
    end

endmodule

// ==== rx_intf_top.sv ====
// rx_intf_top: register block, byte packer, data and descriptor FIFOs and stream output
`timescale 1ns/1ps
`include "rx_intf_defines.svh"

module rx_intf_top
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hdr_strobe,
    input  rx_intf_pkg::pkt_hdr_t  hdr,
    input  logic [7:0]             byte_in,
    input  logic                   byte_strobe,
    input  logic                   fcs_strobe,
    input  logic                   fcs_ok,
    input  rx_intf_pkg::axil_req_t axil_req,
    input  logic                   m_axis_tready,
    output rx_intf_pkg::axil_rsp_t axil_rsp,
    output rx_intf_pkg::axis_out_t m_axis,
    output logic                   rx_pkt_intr
);
    rx_intf_pkg::rx_ctrl_t               ctrl;
    logic                                refused_pulse;
    logic                                discard_pulse;
    logic                                deliver_pulse;
    logic [15:0]                         next_sn;
    logic                                word_push;
    rx_intf_pkg::rx_word_t               word_push_data;
    logic                                word_pop;
    rx_intf_pkg::rx_word_t               word_pop_data;
    logic                                word_empty;
    logic [$clog2(`RX_DATA_DEPTH+1)-1:0] data_count;
    logic                                desc_push;
    rx_intf_pkg::pkt_desc_t              desc_push_data;
    logic                                desc_pop;
    rx_intf_pkg::pkt_desc_t              desc_pop_data;
    logic                                desc_empty;
    logic                                desc_full;

    rx_intf_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .axil_req      (axil_req),
        .refused_pulse (refused_pulse),
        .discard_pulse (discard_pulse),
        .deliver_pulse (deliver_pulse),
        .next_sn       (next_sn),
        .axil_rsp      (axil_rsp),
        .ctrl          (ctrl)
    );

    rx_byte_packer u_packer (
        .clk           (clk),
        .rst           (rst),
        .ctrl_enable   (ctrl.enable),
        .hdr_strobe    (hdr_strobe),
        .hdr           (hdr),
        .byte_in       (byte_in),
        .byte_strobe   (byte_strobe),
        .fcs_strobe    (fcs_strobe),
        .fcs_ok        (fcs_ok),
        .data_count    (data_count),
        .desc_full     (desc_full),
        .word_push     (word_push),
        .word_data     (word_push_data),
        .desc_push     (desc_push),
        .desc_data     (desc_push_data),
        .refused_pulse (refused_pulse),
        .next_sn       (next_sn)
    );

    // packet words, header word first
    rx_sync_fifo #(
        .DEPTH     (`RX_DATA_DEPTH),
        .payload_t (rx_intf_pkg::rx_word_t)
    ) u_data_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (word_push),
        .push_data (word_push_data),
        .pop       (word_pop),
        .pop_data  (word_pop_data),
        .empty     (word_empty),
        .full      (),
        .count     (data_count)
    );

    rx_sync_fifo #(
        .DEPTH     (`RX_DESC_DEPTH),
        .payload_t (rx_intf_pkg::pkt_desc_t)
    ) u_desc_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (desc_push),
        .push_data (desc_push_data),
        .pop       (desc_pop),
        .pop_data  (desc_pop_data),
        .empty     (desc_empty),
        .full      (desc_full),
        .count     ()
    );

    rx_stream_out u_stream_out (
        .clk           (clk),
        .rst           (rst),
        .drop_bad_fcs  (ctrl.drop_bad_fcs),
        .intr_enable   (ctrl.intr_enable),
        .word_data     (word_pop_data),
        .word_empty    (word_empty),
        .desc_data     (desc_pop_data),
        .desc_empty    (desc_empty),
        .m_axis_tready (m_axis_tready),
        .word_pop      (word_pop),
        .desc_pop      (desc_pop),
        .m_axis        (m_axis),
        .discard_pulse (discard_pulse),
        .deliver_pulse (deliver_pulse),
        .rx_pkt_intr   (rx_pkt_intr)
    );

endmodule

// ==== rx_stream_out.sv ====
// rx_stream_out: sends queued packets as AXI4-Stream bursts, discards bad-FCS packets, packet interrupt
`timescale 1ns/1ps
`include "rx_intf_defines.svh"

module rx_stream_out
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   drop_bad_fcs,
    input  logic                   intr_enable,
    input  rx_intf_pkg::rx_word_t  word_data,
    input  logic                   word_empty,
    input  rx_intf_pkg::pkt_desc_t desc_data,
    input  logic                   desc_empty,
    input  logic                   m_axis_tready,
    output logic                   word_pop,
    output logic                   desc_pop,
    output rx_intf_pkg::axis_out_t m_axis,
    output logic                   discard_pulse,
    output logic                   deliver_pulse,
    output logic                   rx_pkt_intr
);
    typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_DROP} state_t;

    state_t      state;
    logic [15:0] words_left;
    logic        last_word;

    assign last_word = (words_left == 16'd1);

    // the descriptor lands with the last word, so a whole packet is queued
    assign m_axis.tvalid = (state == ST_SEND) && !word_empty;
    assign m_axis.tdata  = word_data.data;
    assign m_axis.tlast  = (state == ST_SEND) && last_word;

    assign word_pop = !word_empty
                    && (((state == ST_SEND) && m_axis_tready) || (state == ST_DROP));
    assign desc_pop = word_pop && last_word;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= ST_IDLE;
            words_left    <= '0;
            discard_pulse <= 1'b0;
            deliver_pulse <= 1'b0;
            rx_pkt_intr   <= 1'b0;
        end
        else
        begin
            discard_pulse <= 1'b0;
            deliver_pulse <= 1'b0;
            rx_pkt_intr   <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (!desc_empty)
                    begin
                        words_left <= desc_data.num_words;
                        state      <= (drop_bad_fcs && !desc_data.fcs_ok) ? ST_DROP : ST_SEND;
                    end
                end
                default:
                begin
                    if (word_pop)
                    begin
                        words_left <= words_left - 1'b1;
                        if (last_word)
                        begin
                            state <= ST_IDLE;
                            if (state == ST_SEND)
                            begin
                                deliver_pulse <= 1'b1;
                                rx_pkt_intr   <= intr_enable;
                            end
                            else
                            begin
                                discard_pulse <= 1'b1;
                            end
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== rx_sync_fifo.sv ====
// rx_sync_fifo: single-clock circular buffer with a typed payload and occupancy count
`timescale 1ns/1ps
`include "rx_intf_defines.svh"

module rx_sync_fifo
#(
    parameter int  DEPTH     = `RX_DESC_DEPTH,
    parameter type payload_t = logic [7:0]
)
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     pop_data,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]  count
);
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    assign pop_data = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == ($clog2(DEPTH+1))'(DEPTH));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

endmodule

// ==== tb_rx_intf.sv ====
// testbench for rx_intf_top: clock, reset, AXI4-Lite tasks, packet stimulus, reference model, compare
`timescale 1ns/1ps
`include "rx_intf_defines.svh"

module tb_rx_intf;

    typedef logic [7:0] byte_list_t [$];
    typedef logic [`RX_WORD_W-1:0] word_list_t [$];

    // one expected stream beat
    typedef struct packed {
        logic [`RX_WORD_W-1:0] data;
        logic                  last;
    } beat_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   hdr_strobe;
    rx_intf_pkg::pkt_hdr_t  hdr;
    logic [7:0]             byte_in;
    logic                   byte_strobe;
    logic                   fcs_strobe;
    logic                   fcs_ok;
    rx_intf_pkg::axil_req_t axil_req;
    rx_intf_pkg::axil_rsp_t axil_rsp;
    logic                   m_axis_tready;
    rx_intf_pkg::axis_out_t m_axis;
    logic                   rx_pkt_intr;

    beat_t       exp_q [$];
    beat_t       cur;
    int          tready_mode = 0;
    int          intr_count = 0;
    int          beat_idx = 0;
    logic [2:0]  ctrl_shadow;
    logic [15:0] model_sn;
    int          delivered_model;
    int          dropped_model;
    int          fixed_lens [6] = '{8, 16, 1, 7, 13, 24};

    rx_intf_top dut (
        .clk           (clk),
        .rst           (rst),
        .hdr_strobe    (hdr_strobe),
        .hdr           (hdr),
        .byte_in       (byte_in),
        .byte_strobe   (byte_strobe),
        .fcs_strobe    (fcs_strobe),
        .fcs_ok        (fcs_ok),
        .axil_req      (axil_req),
        .m_axis_tready (m_axis_tready),
        .axil_rsp      (axil_rsp),
        .m_axis        (m_axis),
        .rx_pkt_intr   (rx_pkt_intr)
    );

    always #50 clk = ~clk;

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error at time %0t: %s got %h expected %h", $time, what, got, exp);
        $display("sim failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    // header word, then data words filled from bit 0 upward and zero padded
    function automatic word_list_t expected_words(input logic [15:0] len, input logic [7:0] rate,
                                                  input logic aggr, input logic sgi,
                                                  input byte_list_t bytes,
                                                  input logic [15:0] sn);
        word_list_t            words;
        logic [`RX_WORD_W-1:0] w;
        int                    i;
        w = '0;
        w[63:48] = sn;
        w[47:32] = len;
        w[31:24] = rate;
        w[1]     = sgi;
        w[0]     = aggr;
        words.push_back(w);
        w = '0;
        for (i = 0; i < int'(len); i++)
        begin
            w[(i % 8) * 8 +: 8] = bytes[i];
            if (i % 8 == 7)
            begin
                words.push_back(w);
                w = '0;
            end
        end
        if (len[2:0] != 3'd0)
            words.push_back(w);
        return words;
    endfunction

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        int n;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hF;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        step_cycle();
        for (n = 0; n < 50 && !axil_rsp.awready; n++)
            step_cycle();
        assert (axil_rsp.awready)
        else report_failure("timeout waiting for AXI4-Lite awready");
        assert (axil_rsp.wready)
        else report_mismatch("wready with awready", {63'd0, axil_rsp.wready}, 64'd1);
        // valid stays up through the handshake edge
        step_cycle();
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        for (n = 0; n < 50 && !axil_rsp.bvalid; n++)
            step_cycle();
        assert (axil_rsp.bvalid)
        else report_failure("timeout waiting for AXI4-Lite bvalid");
        assert (axil_rsp.bresp == 2'b00)
        else report_mismatch("bresp", {62'd0, axil_rsp.bresp}, 64'd0);
        step_cycle();
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int n;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        step_cycle();
        for (n = 0; n < 50 && !axil_rsp.arready; n++)
            step_cycle();
        assert (axil_rsp.arready)
        else report_failure("timeout waiting for AXI4-Lite arready");
        step_cycle();
        axil_req.arvalid = 1'b0;
        for (n = 0; n < 50 && !axil_rsp.rvalid; n++)
            step_cycle();
        assert (axil_rsp.rvalid)
        else report_failure("timeout waiting for AXI4-Lite rvalid");
        assert (axil_rsp.rresp == 2'b00)
        else report_mismatch("rresp", {62'd0, axil_rsp.rresp}, 64'd0);
        data = axil_rsp.rdata;
        step_cycle();
        axil_req.rready = 1'b0;
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] v;
        axil_read(addr, v);
        assert (v == exp)
        else report_mismatch(name, {32'd0, v}, {32'd0, exp});
    endtask

    task automatic set_ctrl(input logic [2:0] value);
        axil_write(`RX_REG_CTRL, {29'd0, value});
        ctrl_shadow = value;
    endtask

    // accepted is 0 for a packet the DUT should ignore or refuse
    task automatic send_packet(input int len, input logic fcs_good, input logic accepted);
        byte_list_t            bytes;
        word_list_t            words;
        rx_intf_pkg::pkt_hdr_t h;
        beat_t                 b;
        int                    i;
        h.rate    = 8'($urandom);
        h.len     = 16'(len);
        h.ht_aggr = 1'($urandom);
        h.ht_sgi  = 1'($urandom);
        for (i = 0; i < len; i++)
            bytes.push_back(8'($urandom));
        if (accepted)
        begin
            if (fcs_good || !ctrl_shadow[1])
            begin
                words = expected_words(h.len, h.rate, h.ht_aggr, h.ht_sgi, bytes, model_sn);
                for (i = 0; i < words.size(); i++)
                begin
                    b.data = words[i];
                    b.last = (i == words.size() - 1);
                    exp_q.push_back(b);
                end
                delivered_model++;
            end
            else
                dropped_model++;
            // bad fcs still uses up a sequence number
            model_sn = model_sn + 16'd1;
        end
        hdr        = h;
        hdr_strobe = 1'b1;
        step_cycle();
        hdr_strobe = 1'b0;
        for (i = 0; i < len; i++)
        begin
            byte_in     = bytes[i];
            byte_strobe = 1'b1;
            step_cycle();
            byte_strobe = 1'b0;
            if ($urandom % 4 == 0)
                step_cycle();
        end
        fcs_ok     = fcs_good;
        fcs_strobe = 1'b1;
        step_cycle();
        fcs_strobe = 1'b0;
        step_cycle();
        step_cycle();
    endtask

    task automatic wait_drained();
        int n;
        for (n = 0; n < 4000 && exp_q.size() != 0; n++)
            step_cycle();
        assert (exp_q.size() == 0)
        else report_failure("timeout waiting for the stream to deliver all packets");
        repeat (4) step_cycle();
    endtask

    // tready: 0 always ready, 1 random stalls, 2 held low
    initial
    begin
        m_axis_tready = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            if (tready_mode == 0)
                m_axis_tready = 1'b1;
            else if (tready_mode == 1)
                m_axis_tready = ($urandom % 4) != 0;
            else
                m_axis_tready = 1'b0;
        end
    end

    // values at the falling edge hold through the next rising edge
    always @(negedge clk)
    begin
        if (!rst && m_axis.tvalid && m_axis_tready)
        begin
            assert (exp_q.size() != 0)
            else report_failure("stream beat arrived when no packet was expected");
            cur = exp_q.pop_front();
            assert (m_axis.tdata == cur.data)
            else report_mismatch($sformatf("tdata of beat %0d", beat_idx), m_axis.tdata, cur.data);
            assert (m_axis.tlast == cur.last)
            else report_mismatch($sformatf("tlast of beat %0d", beat_idx),
                                 {63'd0, m_axis.tlast}, {63'd0, cur.last});
            beat_idx++;
        end
        if (!rst && rx_pkt_intr)
            intr_count++;
    end

    initial
    begin
        int k;
        void'($urandom(32'h1efc5286));
        rst             = 1'b1;
        hdr_strobe      = 1'b0;
        hdr             = '0;
        byte_in         = 8'd0;
        byte_strobe     = 1'b0;
        fcs_strobe      = 1'b0;
        fcs_ok          = 1'b0;
        axil_req        = '0;
        ctrl_shadow     = 3'd0;
        model_sn        = 16'd0;
        delivered_model = 0;
        dropped_model   = 0;
        for (k = 0; k < 3; k++)
            step_cycle();
        rst = 1'b0;

        // register access after reset
        check_reg(`RX_REG_CTRL, 32'd0, "CTRL after reset");
        check_reg(`RX_REG_DELIVERED, 32'd0, "DELIVERED after reset");
        check_reg(`RX_REG_DROPPED, 32'd0, "DROPPED after reset");
        check_reg(`RX_REG_NEXT_SN, 32'd0, "NEXT_SN after reset");
        set_ctrl(3'b101);
        check_reg(`RX_REG_CTRL, 32'd5, "CTRL readback");
        set_ctrl(3'b001);

        // packing, full and partial last words
        for (k = 0; k < 6; k++)
            send_packet(fixed_lens[k], 1'b1, 1'b1);
        for (k = 0; k < 6; k++)
            send_packet(1 + int'($urandom % 48), 1'b1, 1'b1);
        wait_drained();
        check_reg(`RX_REG_NEXT_SN, {16'd0, model_sn}, "NEXT_SN after packing");

        // random back-pressure
        tready_mode = 1;
        for (k = 0; k < 6; k++)
            send_packet(1 + int'($urandom % 48), 1'b1, 1'b1);
        wait_drained();
        tready_mode = 0;

        // bad fcs with and without discard
        set_ctrl(3'b011);
        send_packet(20, 1'b0, 1'b1);
        send_packet(12, 1'b1, 1'b1);
        wait_drained();
        check_reg(`RX_REG_DROPPED, 32'(dropped_model), "DROPPED after discard");
        set_ctrl(3'b001);
        send_packet(17, 1'b0, 1'b1);
        wait_drained();
        check_reg(`RX_REG_DROPPED, 32'(dropped_model), "DROPPED with discard off");

        // disabled, then a packet that does not fit
        set_ctrl(3'b000);
        send_packet(20, 1'b1, 1'b0);
        repeat (10) step_cycle();
        check_reg(`RX_REG_NEXT_SN, {16'd0, model_sn}, "NEXT_SN while disabled");
        check_reg(`RX_REG_DROPPED, 32'(dropped_model), "DROPPED while disabled");
        set_ctrl(3'b001);
        tready_mode = 2;
        // four packets of 14 words leave 8 free
        for (k = 0; k < 4; k++)
            send_packet(100, 1'b1, 1'b1);
        send_packet(100, 1'b1, 1'b0);
        dropped_model++;
        repeat (4) step_cycle();
        check_reg(`RX_REG_DROPPED, 32'(dropped_model), "DROPPED after refusal");
        check_reg(`RX_REG_NEXT_SN, {16'd0, model_sn}, "NEXT_SN after refusal");
        tready_mode = 0;
        wait_drained();

        // interrupt per delivered packet
        assert (intr_count == 0)
        else report_mismatch("interrupts while disabled", 64'(intr_count), 64'd0);
        set_ctrl(3'b101);
        tready_mode = 1;
        for (k = 0; k < 5; k++)
            send_packet(1 + int'($urandom % 40), 1'b1, 1'b1);
        wait_drained();
        tready_mode = 0;
        assert (intr_count == 5)
        else report_mismatch("interrupt pulse count", 64'(intr_count), 64'd5);
        check_reg(`RX_REG_DELIVERED, 32'(delivered_model), "DELIVERED");

        repeat (20) step_cycle();
        $display("sim passed");
        $finish;
    end

endmodule
